//--- mont_mul.f
+incdir+hdl
hdl/mont_data_pkg.sv
hdl/mont_ctrl_pkg.sv
hdl/mont_step_if.sv
hdl/multiple_table.sv
hdl/mp_adder.sv
hdl/mont_datapath.sv
hdl/mont_ctrl.sv
hdl/mont_mul.sv
sim/mont_mul_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mont_mul_tb
FILELIST  = mont_mul.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/mont_mul_tb.sv
`timescale 1ns/1ps
`include "mont_params.svh"

module mont_mul_tb;
    import mont_data_pkg::*;

    localparam int N_VEC   = 10;
    localparam int TIMEOUT = 5 * `MONT_ITER + 200;

    // one stimulus row with its golden result
    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t m;
        logic     rnd;
        logic     busy;
        operand_t expected;
    } vec_t;

    logic        clk;
    logic        resetn;
    logic        start;
    operand_t    in_a;
    operand_t    in_b;
    operand_t    in_m;
    operand_t    result;
    logic        done;
    vec_t        vec_table [N_VEC];
    logic [31:0] lfsr;

    mont_mul mont_mul_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_random(output operand_t v);
        for (int i = 0; i < `MONT_WIDTH; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // bit-serial reference, one bit of a per step
    function automatic operand_t mont_reference(input operand_t a, input operand_t b,
                                                input operand_t m);
        logic [`MONT_WIDTH+1:0] t;
        t = '0;
        for (int i = 0; i < `MONT_WIDTH; i++) begin
            if (a[i]) begin
                t = t + {2'b00, b};
            end
            if (t[0]) begin
                t = t + {2'b00, m};
            end
            t = t >> 1;
        end
        if (t >= {2'b00, m}) begin
            t = t - {2'b00, m};
        end
        return t[`MONT_WIDTH-1:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_operand(input string name, input operand_t got, input operand_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // drive and sample just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_row(input int idx, input operand_t a, input operand_t b,
                           input operand_t m, input logic rnd, input logic busy);
        vec_table[idx] = '{a: a, b: b, m: m, rnd: rnd, busy: busy, expected: '0};
    endtask

    task automatic build_table();
        operand_t mf1;
        operand_t mf3;
        operand_t pat;
        // moduli ending in 01 and 11 reach all q cases
        mf1 = {16{64'hc5a3_96e1_7b2d_4f09}};
        mf3 = {16{64'hd1e4_58b7_a20c_63f3}};
        pat = {16{64'h5a69_3c0f_e1d2_8b47}};
        set_row(0, '0, pat, mf1, 1'b0, 1'b0);
        set_row(1, 1, pat, mf3, 1'b0, 1'b1);
        set_row(2, pat, 1, mf1, 1'b0, 1'b0);
        set_row(3, mf1 - 1, mf1 - 2, mf1, 1'b0, 1'b0);
        set_row(4, mf3 - 1, mf3 - 3, mf3, 1'b0, 1'b0);
        set_row(5, '0, '0, 1, 1'b0, 1'b0);
        set_row(6, 2, 1, 3, 1'b0, 1'b0);
        for (int i = 7; i < N_VEC; i++) begin
            set_row(i, '0, '0, '0, 1'b1, (i == 8));
        end
        for (int i = 0; i < N_VEC; i++) begin
            if (vec_table[i].rnd) begin
                draw_random(vec_table[i].m);
                draw_random(vec_table[i].a);
                draw_random(vec_table[i].b);
                // odd m with the top bit set, a and b with it clear
                vec_table[i].m[0]            = 1'b1;
                vec_table[i].m[`MONT_WIDTH-1] = 1'b1;
                vec_table[i].a[`MONT_WIDTH-1] = 1'b0;
                vec_table[i].b[`MONT_WIDTH-1] = 1'b0;
            end
            vec_table[i].expected = mont_reference(vec_table[i].a, vec_table[i].b,
                                                   vec_table[i].m);
        end
    endtask

    // optional start pulse mid-run carrying a different a
    task automatic wait_done(input logic poke, input int idx);
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                abort_run($sformatf("done never arrived for entry %0d", idx));
            end
            next_cycle();
            start = poke && (cycles == 40);
            if (poke && (cycles == 40 || cycles == 41)) begin
                in_a = ~in_a;
            end
            cycles++;
        end
    endtask

    task automatic run_entry(input int idx);
        vec_t v;
        v     = vec_table[idx];
        in_a  = v.a;
        in_b  = v.b;
        in_m  = v.m;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        wait_done(v.busy, idx);
        check_operand("result", result, v.expected);
        next_cycle();
        check_flag("done", done, 1'b0);
        check_operand("result", result, v.expected);
        // long quiet window with no second done and result held
        if (v.busy) begin
            for (int i = 0; i < TIMEOUT; i++) begin
                next_cycle();
                check_flag("done", done, 1'b0);
                check_operand("result", result, v.expected);
            end
        end
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        lfsr   = 32'h92e0;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            check_flag("done", done, 1'b0);
        end
        for (int i = 0; i < N_VEC; i++) begin
            run_entry(i);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- hdl/mont_mul.sv
`timescale 1ns/1ps

module mont_mul (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  mont_data_pkg::operand_t in_a,
    input  mont_data_pkg::operand_t in_b,
    input  mont_data_pkg::operand_t in_m,
    output mont_data_pkg::operand_t result,
    output logic                    done
);

    // per-cycle commands and status between sequencer and datapath
    mont_step_if step ();

    mont_ctrl mont_ctrl_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .m_low  (in_m[1:0]),
        .done   (done),
        .step   (step.ctrl)
    );

    mont_datapath mont_datapath_inst (
        .clk    (clk),
        .resetn (resetn),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .step   (step.dp)
    );

endmodule

//--- hdl/mont_ctrl.sv
`timescale 1ns/1ps
`include "mont_params.svh"

module mont_ctrl (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic [1:0] m_low,
    output logic       done,
    mont_step_if.ctrl  step
);
    import mont_data_pkg::*;
    import mont_ctrl_pkg::*;

    localparam int ITER_W = $clog2(`MONT_ITER);

    mont_state_e       state;
    mont_state_e       next_state;
    logic [ITER_W-1:0] iter;
    logic              issued;
    logic              last_iter;
    mult_sel_e         q_sel;

    // q = -acc * m^-1 mod 4, and m^-1 mod 4 equals m mod 4 for odd m
    always_comb begin
        case (step.acc_low)
            2'b01:   q_sel = (m_low == 2'b01) ? M3 : M;
            2'b10:   q_sel = M2;
            2'b11:   q_sel = (m_low == 2'b01) ? M : M3;
            default: q_sel = ZERO;
        endcase
    end

    assign last_iter = (iter == ITER_W'(`MONT_ITER - 1));

    always_comb begin
        step.load      = 1'b0;
        step.add_start = 1'b0;
        step.subtract  = 1'b0;
        step.sel       = ZERO;
        step.pre_sel   = 2'b00;
        step.acc_shift = 1'b0;
        step.res_en    = 1'b0;
        next_state     = state;
        case (state)
            IDLE: begin
                if (start) begin
                    step.load  = 1'b1;
                    next_state = PRE_M3;
                end
            end
            PRE_M3: begin
                step.pre_sel   = 2'b01;
                step.add_start = !issued;
                if (step.add_done) begin
                    next_state = PRE_B3;
                end
            end
            PRE_B3: begin
                step.pre_sel   = 2'b10;
                step.add_start = !issued;
                if (step.add_done) begin
                    next_state = LOOP_ADD_B;
                end
            end
            LOOP_ADD_B: begin
                // digit value maps straight onto B, B2, B3
                step.sel       = mult_sel_e'({1'b0, step.a_digit});
                step.add_start = 1'b1;
                next_state     = LOOP_WAIT_B;
            end
            LOOP_WAIT_B: begin
                if (step.add_done) begin
                    next_state = LOOP_ADD_M;
                end
            end
            LOOP_ADD_M: begin
                step.sel       = q_sel;
                step.add_start = 1'b1;
                next_state     = LOOP_WAIT_M;
            end
            LOOP_WAIT_M: begin
                if (step.add_done) begin
                    step.acc_shift = 1'b1;
                    next_state     = last_iter ? RED_SUB : LOOP_ADD_B;
                end
            end
            RED_SUB: begin
                step.sel       = M;
                step.subtract  = 1'b1;
                step.add_start = !issued;
                // one add of m after going below zero restores the residue
                if (step.add_done && step.neg) begin
                    next_state = RED_ADD;
                end
            end
            RED_ADD: begin
                step.sel       = M;
                step.add_start = !issued;
                if (step.add_done) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                step.res_en = 1'b1;
                next_state  = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= IDLE;
            issued <= 1'b0;
            iter   <= '0;
            done   <= 1'b0;
        end else begin
            state <= next_state;
            done  <= (state == FINISH);
            if (step.add_done) begin
                issued <= 1'b0;
            end else if (step.add_start) begin
                issued <= 1'b1;
            end
            if (state == IDLE) begin
                iter <= '0;
            end else if (step.acc_shift) begin
                iter <= iter + 1'b1;
            end
        end
    end

    // every adder result answers an operation still outstanding
    assert property (@(posedge clk) disable iff (!resetn)
        step.add_done |-> issued)
        else $error("adder result arrived with no operation outstanding");

endmodule

//--- hdl/mont_datapath.sv
`timescale 1ns/1ps

module mont_datapath (
    input  logic                    clk,
    input  logic                    resetn,
    input  mont_data_pkg::operand_t in_a,
    input  mont_data_pkg::operand_t in_b,
    input  mont_data_pkg::operand_t in_m,
    output mont_data_pkg::operand_t result,
    mont_step_if.dp                 step
);
    import mont_data_pkg::*;

    operand_t    a_reg;
    wide_t       acc;
    wide_t       multiple;
    wide_t       pre_base;
    wide_t       op_a;
    wide_t       op_b;
    add_result_u sum;
    logic        store_3b;
    logic        store_3m;

    // a is consumed from the low end
    always_ff @(posedge clk) begin
        if (step.load) begin
            a_reg <= in_a;
        end else if (step.acc_shift) begin
            a_reg <= a_reg >> 2;
        end
    end

    // precompute adds b or m to its own double
    assign pre_base = step.pre_sel[1] ? wide_t'(in_b) : wide_t'(in_m);
    assign op_a     = (step.pre_sel != 2'b00) ? pre_base : acc;
    assign op_b     = (step.pre_sel != 2'b00) ? (pre_base << 1) : multiple;

    assign store_3m = step.add_done && step.pre_sel[0];
    assign store_3b = step.add_done && step.pre_sel[1];

    multiple_table multiple_table_inst (
        .clk      (clk),
        .in_b     (in_b),
        .in_m     (in_m),
        .store_3b (store_3b),
        .store_3m (store_3m),
        .sum3     (sum.sum),
        .sel      (step.sel),
        .multiple (multiple)
    );

    mp_adder mp_adder_inst (
        .clk      (clk),
        .resetn   (resetn),
        .start    (step.add_start),
        .subtract (step.subtract),
        .op_a     (op_a),
        .op_b     (op_b),
        .sum      (sum),
        .done     (step.add_done)
    );

    // shift can ride along with the last add of an iteration
    always_ff @(posedge clk) begin
        if (step.load) begin
            acc <= '0;
        end else if (step.add_done && step.pre_sel == 2'b00) begin
            acc <= step.acc_shift ? (sum.sum >> 2) : sum.sum;
        end else if (step.acc_shift) begin
            acc <= acc >> 2;
        end
    end

    always_ff @(posedge clk) begin
        if (step.res_en) begin
            result <= operand_t'(acc);
        end
    end

    assign step.a_digit = a_reg[1:0];
    assign step.acc_low = acc[1:0];
    assign step.neg     = sum.diff.neg;

endmodule

//--- hdl/mp_adder.sv
`timescale 1ns/1ps

module mp_adder (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  logic                       subtract,
    input  mont_data_pkg::wide_t       op_a,
    input  mont_data_pkg::wide_t       op_b,
    output mont_data_pkg::add_result_u sum,
    output logic                       done
);

    // two's complement, the top bit is the sign of a difference
    always_ff @(posedge clk) begin
        if (start) begin
            if (subtract) begin
                sum.sum <= op_a - op_b;
            end else begin
                sum.sum <= op_a + op_b;
            end
        end
    end

    // result is ready one cycle after start
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) start |=> !start)
        else $error("adder restarted before its result came back");

endmodule

//--- hdl/multiple_table.sv
`timescale 1ns/1ps

module multiple_table (
    input  logic                     clk,
    input  mont_data_pkg::operand_t  in_b,
    input  mont_data_pkg::operand_t  in_m,
    input  logic                     store_3b,
    input  logic                     store_3m,
    input  mont_data_pkg::wide_t     sum3,
    input  mont_data_pkg::mult_sel_e sel,
    output mont_data_pkg::wide_t     multiple
);
    import mont_data_pkg::*;

    wide_t b3;
    wide_t m3;

    // triples come from the shared adder during precompute
    always_ff @(posedge clk) begin
        if (store_3b) begin
            b3 <= sum3;
        end
        if (store_3m) begin
            m3 <= sum3;
        end
    end

    // doubles are plain shifts of the inputs
    always_comb begin
        case (sel)
            B:       multiple = wide_t'(in_b);
            B2:      multiple = wide_t'(in_b) << 1;
            B3:      multiple = b3;
            M:       multiple = wide_t'(in_m);
            M2:      multiple = wide_t'(in_m) << 1;
            M3:      multiple = m3;
            default: multiple = '0;
        endcase
    end

    // precompute forms one triple per adder pass
    assert property (@(posedge clk) !(store_3b && store_3m))
        else $error("3B and 3M stored on the same cycle");

endmodule

//--- hdl/mont_step_if.sv
`timescale 1ns/1ps

interface mont_step_if;
    import mont_data_pkg::*;

    // commands from the sequencer
    logic       load;
    logic       add_start;
    logic       subtract;
    mult_sel_e  sel;
    logic [1:0] pre_sel;    // bit 0 forms 3M, bit 1 forms 3B
    logic       acc_shift;
    logic       res_en;

    // status from the datapath
    logic       add_done;
    logic       neg;
    logic [1:0] a_digit;
    logic [1:0] acc_low;

    modport ctrl (
        output load, add_start, subtract, sel, pre_sel, acc_shift, res_en,
        input  add_done, neg, a_digit, acc_low
    );

    modport dp (
        input  load, add_start, subtract, sel, pre_sel, acc_shift, res_en,
        output add_done, neg, a_digit, acc_low
    );

endinterface

//--- hdl/mont_ctrl_pkg.sv
package mont_ctrl_pkg;

    // sequencer states
    typedef enum logic [3:0] {
        IDLE        = 4'd0,
        PRE_M3      = 4'd1,
        PRE_B3      = 4'd2,
        LOOP_ADD_B  = 4'd3,
        LOOP_WAIT_B = 4'd4,
        LOOP_ADD_M  = 4'd5,
        LOOP_WAIT_M = 4'd6,
        RED_SUB     = 4'd7,
        RED_ADD     = 4'd8,
        FINISH      = 4'd9
    } mont_state_e;

endpackage

//--- hdl/mont_data_pkg.sv
`include "mont_params.svh"

package mont_data_pkg;

    typedef logic [`MONT_WIDTH-1:0] operand_t;

    // holds sums up to 8m plus a sign bit
    typedef logic [`MONT_WIDTH+`MONT_EXT-1:0] wide_t;

    // one adder word, seen as a plain sum or as a signed difference
    typedef union packed {
        wide_t sum;
        struct packed {
            logic                             neg;
            logic [`MONT_WIDTH+`MONT_EXT-2:0] mag;
        } diff;
    } add_result_u;

    // addend picked from the multiple table
    typedef enum logic [2:0] {
        ZERO = 3'd0,
        B    = 3'd1,
        B2   = 3'd2,
        B3   = 3'd3,
        M    = 3'd4,
        M2   = 3'd5,
        M3   = 3'd6
    } mult_sel_e;

endpackage

//--- hdl/mont_params.svh
`ifndef MONT_PARAMS_SVH
`define MONT_PARAMS_SVH

// operand width in bits
`define MONT_WIDTH 1024

// guard bits above the operand in internal words
`define MONT_EXT 4

// a is consumed two bits per iteration
`define MONT_ITER (`MONT_WIDTH / 2)

`endif
